// File: common/axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

   // back-end bus geometry
   localparam int AXI_ADDR_W  = 32;
   localparam int BE_DATA_W   = 64;            // power-of-two multiple of the fe word
   localparam int BE_NBYTES   = BE_DATA_W / 8;
   localparam int BE_NBYTES_W = $clog2(BE_NBYTES);

   typedef logic [1:0] resp_t;

   // write response codes
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // address channel payload
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;           // aligned to the back-end word
   } aw_t;

   // data channel payload
   typedef struct packed {
      logic [BE_DATA_W-1:0] data;
      logic [BE_NBYTES-1:0] strb;            // byte lanes to write
   } w_t;

   // response channel payload
   typedef struct packed {
      resp_t resp;
   } b_t;

endpackage

`default_nettype wire

// File: common/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

   // front-end word and address geometry
   localparam int FE_DATA_W   = 32;
   localparam int ADDR_W      = 32;
   localparam int FE_NBYTES   = FE_DATA_W / 8;   // bytes per front-end word
   localparam int FE_NBYTES_W = $clog2(FE_NBYTES);

   // write buffer depth unless the top level overrides it
   localparam int BUF_DEPTH_DEF = 4;

   typedef logic [ADDR_W-1:0]    fe_addr_t;     // byte address
   typedef logic [FE_DATA_W-1:0] fe_data_t;
   typedef logic [FE_NBYTES-1:0] fe_strb_t;     // one bit per byte

   // one front-end store, 68 bits
   typedef struct packed {
      fe_addr_t addr;
      fe_data_t data;
      fe_strb_t strb;
   } fe_req_t;

endpackage

`default_nettype wire

// File: files.f
common/cache_cfg_pkg.sv
common/axi_wr_pkg.sv
logic/write_buffer.sv
write_channel/write_channel_axi.sv
logic/cache_write_path.sv
sim/write_path_chk.sv
sim/axi_mem_slave.sv
sim/write_path_checker.sv
sim/tb_cache_write_path.sv

// File: logic/cache_write_path.sv
`timescale 1ns/1ps
`default_nettype none

module cache_write_path #(
   parameter int BUF_DEPTH = cache_cfg_pkg::BUF_DEPTH_DEF
) (
   input  wire                         clk_i,
   input  wire                         reset_i,
   // front-end stores
   input  wire                         fe_valid_i,
   input  wire cache_cfg_pkg::fe_req_t fe_req_i,
   output logic                        fe_ready_o,
   // AXI write master
   output logic                        awvalid_o,
   output axi_wr_pkg::aw_t             aw_o,
   input  wire                         awready_i,
   output logic                        wvalid_o,
   output axi_wr_pkg::w_t              w_o,
   input  wire                         wready_i,
   input  wire                         bvalid_i,
   input  wire axi_wr_pkg::b_t         b_i,
   output logic                        bready_o,
   output logic                        idle_o
);

   cache_cfg_pkg::fe_req_t head;
   logic                   buf_full;
   logic                   buf_empty;
   logic                   ch_pop;
   logic                   ch_busy;

   assign fe_ready_o = ~buf_full;
   assign idle_o     = buf_empty & ~ch_busy;   // nothing queued, nothing in flight

   write_buffer #(
      .DEPTH (BUF_DEPTH)
   ) write_buffer_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_i     (fe_valid_i & fe_ready_o),   // only on a front-end handshake
      .push_req_i (fe_req_i),
      .full_o     (buf_full),
      .pop_i      (ch_pop),
      .head_o     (head),
      .empty_o    (buf_empty)
   );

   write_channel_axi write_channel_axi_i (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .valid_i   (~buf_empty),
      .req_i     (head),
      .pop_o     (ch_pop),
      .busy_o    (ch_busy),
      .awvalid_o (awvalid_o),
      .aw_o      (aw_o),
      .awready_i (awready_i),
      .wvalid_o  (wvalid_o),
      .w_o       (w_o),
      .wready_i  (wready_i),
      .bvalid_i  (bvalid_i),
      .b_i       (b_i),
      .bready_o  (bready_o)
   );

endmodule

`default_nettype wire

// File: logic/write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module write_buffer #(
   parameter int DEPTH = cache_cfg_pkg::BUF_DEPTH_DEF
) (
   input  wire                    clk_i,
   input  wire                    reset_i,
   input  wire                    push_i,
   input  wire cache_cfg_pkg::fe_req_t push_req_i,
   output logic                   full_o,
   input  wire                    pop_i,
   output cache_cfg_pkg::fe_req_t head_o,
   output logic                   empty_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   cache_cfg_pkg::fe_req_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign full_o  = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);

   // a pop makes room, so push is fine when full and popping
   assign do_pop  = pop_i & ~empty_o;
   assign do_push = push_i & (~full_o | do_pop);

   assign head_o = mem[rd_ptr];   // read straight from storage

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_req_i;
      end
   end

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
               wr_ptr <= '0;   // wrap
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (do_pop) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_write_path \
   -f files.f --Mdir obj_dir || exit 1
out="$(./obj_dir/Vtb_cache_write_path)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1

// File: sim/axi_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_slave #(
   parameter logic [31:0] SEED = 32'h0000_0001
) (
   input  wire                  clk_i,
   input  wire                  reset_i,
   input  wire                  awvalid_i,
   input  wire axi_wr_pkg::aw_t aw_i,
   output logic                 awready_o,
   input  wire                  wvalid_i,
   input  wire axi_wr_pkg::w_t  w_i,
   output logic                 wready_o,
   output logic                 bvalid_o,
   output axi_wr_pkg::b_t       b_o,
   input  wire                  bready_i
);

   logic [7:0]  mem [logic [31:0]];   // sparse byte memory
   logic [31:0] err_q [$];            // aligned addresses that get one SLVERR
   logic [31:0] rnd;
   logic [31:0] beat_addr;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic void mark_error(input logic [31:0] addr);
      err_q.push_back(addr);
   endfunction

   function automatic logic [7:0] read_byte(input logic [31:0] addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return 8'hxx;
   endfunction

   function automatic int num_bytes();
      return mem.num();
   endfunction

   // drops the address from the list so the retry succeeds
   function automatic bit take_error(input logic [31:0] addr);
      for (int i = 0; i < err_q.size(); i++) begin
         if (err_q[i] == addr) begin
            err_q.delete(i);
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   always @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         rnd       <= SEED;
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         bvalid_o  <= 1'b0;
         b_o       <= '0;
         beat_addr <= '0;
      end else begin
         rnd       <= xorshift32(rnd);
         awready_o <= (rnd[1:0] != 2'b00);   // ready about three cycles in four
         wready_o  <= (rnd[5:4] != 2'b00);
         if (awvalid_i && awready_o) begin
            beat_addr <= aw_i.addr;
         end
         if (wvalid_i && wready_o) begin
            bvalid_o <= 1'b1;
            if (take_error(beat_addr)) begin
               b_o.resp <= axi_wr_pkg::RESP_SLVERR;   // memory untouched
            end else begin
               b_o.resp <= axi_wr_pkg::RESP_OKAY;
               for (int i = 0; i < 8; i++) begin
                  if (w_i.strb[i]) begin
                     mem[beat_addr + 32'(i)] = w_i.data[8*i +: 8];
                  end
               end
            end
         end else if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/tb_cache_write_path.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_write_path;

   localparam int BUF_DEPTH     = 4;
   localparam int READY_TIMEOUT = 200;   // cycles per store
   localparam int IDLE_TIMEOUT  = 600;

   logic                   clk_i = 1'b0;
   logic                   reset_i;
   logic                   fe_valid_i;
   cache_cfg_pkg::fe_req_t fe_req_i;
   logic                   fe_ready_o;
   logic                   awvalid_o;
   axi_wr_pkg::aw_t        aw_o;
   logic                   awready_i;
   logic                   wvalid_o;
   axi_wr_pkg::w_t         w_o;
   logic                   wready_i;
   logic                   bvalid_i;
   axi_wr_pkg::b_t         b_i;
   logic                   bready_o;
   logic                   idle_o;

   // stimulus table, one entry per test
   string                  row_name [$];
   cache_cfg_pkg::fe_req_t row_req  [$];
   bit                     row_err  [$];

   logic [7:0] image [logic [31:0]];   // byte image the slave memory should end with
   int         tb_errors        = 0;
   int         num_err_rows     = 0;
   bit         saw_backpressure = 1'b0;

   always #50 clk_i = ~clk_i;

   cache_write_path #(
      .BUF_DEPTH (BUF_DEPTH)
   ) cache_write_path_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .fe_valid_i (fe_valid_i),
      .fe_req_i   (fe_req_i),
      .fe_ready_o (fe_ready_o),
      .awvalid_o  (awvalid_o),
      .aw_o       (aw_o),
      .awready_i  (awready_i),
      .wvalid_o   (wvalid_o),
      .w_o        (w_o),
      .wready_i   (wready_i),
      .bvalid_i   (bvalid_i),
      .b_i        (b_i),
      .bready_o   (bready_o),
      .idle_o     (idle_o)
   );

   axi_mem_slave #(
      .SEED (32'he8fa_e2c9)
   ) axi_mem_slave_i (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .awvalid_i (awvalid_o),
      .aw_i      (aw_o),
      .awready_o (awready_i),
      .wvalid_i  (wvalid_o),
      .w_i       (w_o),
      .wready_o  (wready_i),
      .bvalid_o  (bvalid_i),
      .b_o       (b_i),
      .bready_i  (bready_o)
   );

   write_path_checker write_path_checker_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .fe_valid_i (fe_valid_i),
      .fe_ready_i (fe_ready_o),
      .awvalid_i  (awvalid_o),
      .aw_i       (aw_o),
      .awready_i  (awready_i),
      .wvalid_i   (wvalid_o),
      .w_i        (w_o),
      .wready_i   (wready_i),
      .bvalid_i   (bvalid_i),
      .b_i        (b_i),
      .bready_i   (bready_o)
   );

   function automatic void add_row(input string name, input logic [31:0] addr,
                                   input logic [31:0] data, input logic [3:0] strb,
                                   input bit err);
      cache_cfg_pkg::fe_req_t req;
      req.addr = addr;
      req.data = data;
      req.strb = strb;
      row_name.push_back(name);
      row_req.push_back(req);
      row_err.push_back(err);
   endfunction

   function automatic axi_wr_pkg::aw_t expected_aw(input cache_cfg_pkg::fe_req_t req);
      axi_wr_pkg::aw_t aw;
      aw.addr = {req.addr[31:3], 3'b000};   // 8-byte back-end word
      return aw;
   endfunction

   function automatic axi_wr_pkg::w_t expected_w(input cache_cfg_pkg::fe_req_t req);
      axi_wr_pkg::w_t w;
      w.data = {req.data, req.data};
      if (req.addr[2]) begin
         w.strb = {req.strb, 4'b0000};   // upper 32-bit lane
      end else begin
         w.strb = {4'b0000, req.strb};
      end
      return w;
   endfunction

   // later rows overwrite earlier ones, same as on the bus
   function automatic void build_image();
      logic [31:0] word;
      foreach (row_req[r]) begin
         word = {row_req[r].addr[31:2], 2'b00};
         for (int b = 0; b < 4; b++) begin
            if (row_req[r].strb[b]) begin
               image[word + 32'(b)] = row_req[r].data[8*b +: 8];
            end
         end
      end
   endfunction

   task automatic fail_timeout(input string what);
      $display("timeout: %s", what);
      $display("TESTS FAILED");
      $finish;
   endtask

   // called 10 ns after an edge, returns 10 ns after the accepting edge
   task automatic apply_row(input string name, input cache_cfg_pkg::fe_req_t req);
      int waited;
      waited = 0;
      write_path_checker_i.expect_store(name, expected_aw(req), expected_w(req));
      fe_req_i   = req;
      fe_valid_i = 1'b1;   // held until the buffer has room
      while (!fe_ready_o) begin
         saw_backpressure = 1'b1;
         if (waited >= READY_TIMEOUT) begin
            fail_timeout("fe_ready_o stayed low while a store was waiting");
         end
         @(posedge clk_i);
         #10;
         waited++;
      end
      @(posedge clk_i);
      #10;
   endtask

   task automatic compare_memory();
      foreach (image[a]) begin
         if (axi_mem_slave_i.read_byte(a) !== image[a]) begin
            tb_errors++;
            $display("mismatch readback mem[%h] expected %h actual %h",
                     a, image[a], axi_mem_slave_i.read_byte(a));
         end
      end
      if (axi_mem_slave_i.num_bytes() != image.num()) begin
         tb_errors++;
         $display("error: slave memory holds %0d bytes but %0d were written by the stores",
                  axi_mem_slave_i.num_bytes(), image.num());
      end
   endtask

   initial begin
      axi_wr_pkg::aw_t aw;
      int              waited;
      int              total_fail;
      reset_i    = 1'b0;
      fe_valid_i = 1'b0;
      fe_req_i   = '0;
      add_row("full_lane0",   32'h0000_1000, 32'ha1b2_c3d4, 4'b1111, 1'b0);
      add_row("full_lane1",   32'h0000_1004, 32'h1526_3748, 4'b1111, 1'b0);
      add_row("full_lane0_b", 32'h0000_2010, 32'h9a8b_7c6d, 4'b1111, 1'b0);
      add_row("full_lane1_b", 32'h0000_2014, 32'h5e4f_3a2b, 4'b1111, 1'b0);
      add_row("byte0_lane0",  32'h0000_3000, 32'h1122_3344, 4'b0001, 1'b0);
      add_row("byte3_lane1",  32'h0000_3004, 32'h5566_7788, 4'b1000, 1'b0);
      add_row("half_lo",      32'h0000_3008, 32'h99aa_bbcc, 4'b0011, 1'b0);
      add_row("half_hi_l1",   32'h0000_300c, 32'hddee_f1f2, 4'b1100, 1'b0);
      add_row("err_lane0",    32'h0000_4000, 32'hc0de_f00d, 4'b1111, 1'b1);
      add_row("after_err",    32'h0000_4008, 32'h1357_9bdf, 4'b1111, 1'b0);
      add_row("err_lane1",    32'h0000_5004, 32'h2468_ace1, 4'b0110, 1'b1);
      add_row("overwrite_b1", 32'h0000_3000, 32'h7755_3311, 4'b0010, 1'b0);
      add_row("burst_a",      32'h0000_6000, 32'h6a6a_1111, 4'b1111, 1'b0);
      add_row("burst_b",      32'h0000_6004, 32'h6b6b_2222, 4'b1111, 1'b0);
      add_row("burst_c",      32'h0000_6008, 32'h6c6c_3333, 4'b1111, 1'b0);
      add_row("burst_d",      32'h0000_600c, 32'h6d6d_4444, 4'b1111, 1'b0);
      build_image();
      foreach (row_req[r]) begin
         if (row_err[r]) begin
            aw = expected_aw(row_req[r]);
            axi_mem_slave_i.mark_error(aw.addr);
            num_err_rows++;
         end
      end
      #1 reset_i = 1'b1;   // edge on reset so async flops clear
      repeat (5) @(posedge clk_i);
      #10 reset_i = 1'b0;
      if (!idle_o) begin
         tb_errors++;
         $display("error: idle_o is low right after reset");
      end
      // back to back, the slave stalls fill the buffer
      foreach (row_req[r]) begin
         apply_row(row_name[r], row_req[r]);
         if (r == 0 && idle_o) begin
            tb_errors++;
            $display("error: idle_o stayed high after the first store was accepted");
         end
      end
      fe_valid_i = 1'b0;
      waited     = 0;
      while (!idle_o) begin
         if (waited >= IDLE_TIMEOUT) begin
            fail_timeout("idle_o did not return high after the last store");
         end
         @(posedge clk_i);
         #10;
         waited++;
      end
      if (!saw_backpressure) begin
         tb_errors++;
         $display("error: fe_ready_o never dropped during the back-to-back stores");
      end
      if (write_path_checker_i.passed + write_path_checker_i.failed != row_req.size()) begin
         tb_errors++;
         $display("error: only %0d of %0d stores completed with OKAY",
                  write_path_checker_i.passed + write_path_checker_i.failed, row_req.size());
      end
      if (write_path_checker_i.retries != num_err_rows) begin
         tb_errors++;
         $display("error: %0d error responses were injected but %0d retries were seen",
                  num_err_rows, write_path_checker_i.retries);
      end
      compare_memory();
      total_fail = write_path_checker_i.failed + write_path_checker_i.errors + tb_errors;
      $display("tests %0d passed %0d failed %0d other errors %0d", row_req.size(),
               write_path_checker_i.passed, write_path_checker_i.failed,
               write_path_checker_i.errors + tb_errors);
      if (total_fail == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/write_path_checker.sv
`timescale 1ns/1ps
`default_nettype none

module write_path_checker (
   input wire                  clk_i,
   input wire                  reset_i,
   input wire                  fe_valid_i,
   input wire                  fe_ready_i,
   input wire                  awvalid_i,
   input wire axi_wr_pkg::aw_t aw_i,
   input wire                  awready_i,
   input wire                  wvalid_i,
   input wire axi_wr_pkg::w_t  w_i,
   input wire                  wready_i,
   input wire                  bvalid_i,
   input wire axi_wr_pkg::b_t  b_i,
   input wire                  bready_i
);

   // expected beats handed over with each store, not yet accepted
   string           pend_name_q [$];
   axi_wr_pkg::aw_t pend_aw_q   [$];
   axi_wr_pkg::w_t  pend_w_q    [$];
   // accepted stores in order, head is on the bus
   string           name_q [$];
   axi_wr_pkg::aw_t aw_q   [$];
   axi_wr_pkg::w_t  w_q    [$];

   bit head_bad = 1'b0;
   int passed   = 0;
   int failed   = 0;
   int errors   = 0;
   int retries  = 0;

   function automatic void expect_store(input string name, input axi_wr_pkg::aw_t aw,
                                        input axi_wr_pkg::w_t w);
      pend_name_q.push_back(name);
      pend_aw_q.push_back(aw);
      pend_w_q.push_back(w);
   endfunction

   // only the first wrong field of a store is printed
   function automatic void compare(input string field, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
      if (exp_val !== act_val && !head_bad) begin
         head_bad = 1'b1;
         $display("mismatch %s %s expected %h actual %h", name_q[0], field, exp_val, act_val);
      end
   endfunction

   function automatic bit outstanding(input string what);
      if (name_q.size() == 0) begin
         errors++;
         $display("error: %s handshake seen with no accepted store outstanding", what);
         return 1'b0;
      end
      return 1'b1;
   endfunction

   always @(posedge clk_i) begin
      if (!reset_i) begin
         if (fe_valid_i && fe_ready_i) begin
            if (pend_name_q.size() == 0) begin
               errors++;
               $display("error: store accepted with no expected values queued");
            end else begin
               name_q.push_back(pend_name_q.pop_front());
               aw_q.push_back(pend_aw_q.pop_front());
               w_q.push_back(pend_w_q.pop_front());
            end
         end
         if (awvalid_i && awready_i) begin
            if (outstanding("address")) begin
               compare("addr", 64'(aw_q[0].addr), 64'(aw_i.addr));
            end
         end
         if (wvalid_i && wready_i) begin
            if (outstanding("data")) begin
               compare("data", w_q[0].data, w_i.data);
               compare("strb", 64'(w_q[0].strb), 64'(w_i.strb));
            end
         end
         if (bvalid_i && bready_i) begin
            if (outstanding("response")) begin
               if (b_i.resp == axi_wr_pkg::RESP_OKAY) begin
                  if (head_bad) begin
                     failed++;
                  end else begin
                     passed++;
                     $display("pass %s", name_q[0]);
                  end
                  head_bad = 1'b0;
                  name_q.delete(0);
                  aw_q.delete(0);
                  w_q.delete(0);
               end else begin
                  retries++;   // same head goes out again
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/write_path_chk.sv
`timescale 1ns/1ps
`default_nettype none

module write_path_chk (
   input wire                  clk_i,
   input wire                  reset_i,
   input wire                  awvalid_i,
   input wire                  awready_i,
   input wire axi_wr_pkg::aw_t aw_i,
   input wire                  wvalid_i,
   input wire                  bready_i
);

   // data beat only after a completed address beat
   w_after_aw: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(wvalid_i) |-> $past(awvalid_i && awready_i))
      else $error("wvalid rose without a preceding address handshake");

   aw_held: assert property (@(posedge clk_i) disable iff (reset_i)
      awvalid_i && !awready_i |=> awvalid_i)
      else $error("awvalid dropped before awready");

   aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      awvalid_i && !awready_i |=> $stable(aw_i))
      else $error("write address changed while waiting for awready");

   quiet_in_reset: assert property (@(posedge clk_i)
      reset_i |-> !awvalid_i && !wvalid_i && !bready_i)
      else $error("AXI valid or ready high during reset");

endmodule

bind write_channel_axi write_path_chk write_path_chk_i (
   .clk_i     (clk_i),
   .reset_i   (reset_i),
   .awvalid_i (awvalid_o),
   .awready_i (awready_i),
   .aw_i      (aw_o),
   .wvalid_i  (wvalid_o),
   .bready_i  (bready_o)
);

`default_nettype wire

// File: write_channel/write_channel_axi.sv
`timescale 1ns/1ps
`default_nettype none

module write_channel_axi (
   input  wire                         clk_i,
   input  wire                         reset_i,
   // buffered store
   input  wire                         valid_i,
   input  wire cache_cfg_pkg::fe_req_t req_i,
   output logic                        pop_o,
   output logic                        busy_o,
   // AXI write address
   output logic                        awvalid_o,
   output axi_wr_pkg::aw_t             aw_o,
   input  wire                         awready_i,
   // AXI write data
   output logic                        wvalid_o,
   output axi_wr_pkg::w_t              w_o,
   input  wire                         wready_i,
   // AXI write response
   input  wire                         bvalid_i,
   input  wire axi_wr_pkg::b_t         b_i,
   output logic                        bready_o
);

   localparam int ADDR_W      = cache_cfg_pkg::ADDR_W;
   localparam int FE_DATA_W   = cache_cfg_pkg::FE_DATA_W;
   localparam int FE_NBYTES   = cache_cfg_pkg::FE_NBYTES;
   localparam int FE_NBYTES_W = cache_cfg_pkg::FE_NBYTES_W;
   localparam int BE_DATA_W   = axi_wr_pkg::BE_DATA_W;
   localparam int BE_NBYTES   = axi_wr_pkg::BE_NBYTES;
   localparam int BE_NBYTES_W = axi_wr_pkg::BE_NBYTES_W;
   localparam int RATIO       = BE_DATA_W / FE_DATA_W;     // fe words per be word
   localparam int LANE_W      = BE_NBYTES_W - FE_NBYTES_W; // address bits picking the lane

   typedef enum logic [1:0] {
      state_idle,
      state_addr,
      state_write,
      state_verify
   } state_t;

   state_t state;
   state_t state_nxt;

   logic [BE_DATA_W-1:0] be_data;
   logic [BE_NBYTES-1:0] be_strb;
   logic                 resp_ok;

   // geometry the lane logic relies on
   if ((BE_DATA_W % FE_DATA_W) != 0 || (RATIO & (RATIO - 1)) != 0) begin : g_bad_ratio
      $error("back-end width must be a power-of-two multiple of the front-end width");
   end
   if (axi_wr_pkg::AXI_ADDR_W != ADDR_W) begin : g_bad_addr
      $error("AXI address width differs from the store address width");
   end

   // beat payload
   assign aw_o.addr = {req_i.addr[ADDR_W-1:BE_NBYTES_W], {BE_NBYTES_W{1'b0}}};
   assign be_data   = {RATIO{req_i.data}};   // same word on every lane

   if (LANE_W > 0) begin : g_lanes
      logic [LANE_W-1:0] lane;

      assign lane    = req_i.addr[FE_NBYTES_W +: LANE_W];
      assign be_strb = BE_NBYTES'(req_i.strb) << (lane * FE_NBYTES);
   end else begin : g_one_lane
      assign be_strb = req_i.strb;   // buses are the same width
   end

   always_comb begin
      w_o.data = be_data;
      w_o.strb = be_strb;
   end

   assign resp_ok = (b_i.resp == axi_wr_pkg::RESP_OKAY);

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state <= state_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         state_idle: begin
            if (valid_i) begin
               state_nxt = state_addr;
            end
         end
         state_addr: begin
            if (awready_i) begin
               state_nxt = state_write;
            end
         end
         state_write: begin
            if (wready_i) begin
               state_nxt = state_verify;
            end
         end
         default: begin
            // any error resends the same head entry
            if (bvalid_i) begin
               state_nxt = resp_ok ? state_idle : state_addr;
            end
         end
      endcase
   end

   // handshake strobes decoded from the state
   assign awvalid_o = (state == state_addr);
   assign wvalid_o  = (state == state_write);
   assign bready_o  = (state == state_verify);
   assign busy_o    = (state != state_idle);

   assign pop_o = bready_o & bvalid_i & resp_ok;   // entry retires on OKAY only

endmodule

`default_nettype wire
